// ==== common/spi_pins_pkg.sv ====
// SPI pin and event types

package spi_pins_pkg;

    // ----------------------------------------------------------------------
    // Synchronized pin bundle
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic sck;
        logic ss_n;
        logic si;
    } spi_pins_t;

    // Bus idle: clock low, slave deselected
    localparam spi_pins_t PINS_IDLE = '{sck: 1'b0, ss_n: 1'b1, si: 1'b0};

    // ----------------------------------------------------------------------
    // SCK edge events, aligned with their data bit
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic capture;
        logic launch;
        logic selected;
        logic si;
    } spi_event_t;

    localparam spi_event_t EVENT_NONE = '{default: 1'b0};

endpackage

// ==== common/spi_word_pkg.sv ====
// SPI word types

package spi_word_pkg;

    // Bits per SPI word
    localparam int WORD_WIDTH = 8;

    typedef logic [WORD_WIDTH-1:0] spi_word_t;

    // Counts the bits of one word
    typedef logic [$clog2(WORD_WIDTH)-1:0] bit_index_t;

    localparam bit_index_t FIRST_BIT = '0;
    localparam bit_index_t LAST_BIT  = bit_index_t'(WORD_WIDTH - 1);

endpackage

// ==== logic/spi_pin_sync.sv ====
// SPI pin synchronizer

`timescale 1ns/1ps

module spi_pin_sync
    import spi_pins_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      sck,
    input  logic      ss_n,
    input  logic      si,
    output spi_pins_t pins_sync
);

    // First stage, may go metastable
    spi_pins_t pins_meta;

    // ----------------------------------------------------------------------
    // Two flops per pin
    // ----------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            // Idle pattern, so no false edge follows reset
            pins_meta <= PINS_IDLE;
            pins_sync <= PINS_IDLE;
        end else begin
            pins_meta.sck  <= sck;
            pins_meta.ss_n <= ss_n;
            pins_meta.si   <= si;
            pins_sync      <= pins_meta;
        end
    end

endmodule

// ==== logic/spi_edge_detect.sv ====
// SCK edge detector

`timescale 1ns/1ps

module spi_edge_detect
    import spi_pins_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  spi_pins_t  pins_sync,
    output spi_event_t spi_event
);

    // SCK as seen one cycle earlier
    logic sck_prev;

    logic sck_fall;
    logic sck_rise;
    logic selected;

    assign selected = !pins_sync.ss_n;
    assign sck_fall = sck_prev && !pins_sync.sck;
    assign sck_rise = !sck_prev && pins_sync.sck;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            sck_prev <= 1'b0;
        end else begin
            sck_prev <= pins_sync.sck;
        end
    end

    // ----------------------------------------------------------------------
    // Registered events, si and select level travel with the pulses
    // ----------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            spi_event <= EVENT_NONE;
        end else begin
            spi_event.capture  <= sck_fall && selected;
            spi_event.launch   <= sck_rise && selected;
            spi_event.selected <= selected;
            spi_event.si       <= pins_sync.si;
        end
    end

endmodule

// ==== spi_slave/spi_rx_deserializer.sv ====
// SPI receive deserializer

`timescale 1ns/1ps

module spi_rx_deserializer
    import spi_pins_pkg::*, spi_word_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  spi_event_t spi_event,
    output spi_word_t  rx_tdata,
    output logic       rx_tvalid,
    input  logic       rx_tready
);

    bit_index_t            bit_cnt;
    logic [WORD_WIDTH-2:0] shift_q;
    spi_word_t             word_in;
    logic                  word_done;
    logic                  word_held;

    // ----------------------------------------------------------------------
    // Bit counter, restarts whenever the slave is deselected
    // ----------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            bit_cnt <= FIRST_BIT;
        end else if (!spi_event.selected) begin
            bit_cnt <= FIRST_BIT;
        end else if (spi_event.capture) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // First bit in ends up as the MSB
    always_ff @(posedge aclk) begin
        if (spi_event.capture) begin
            shift_q <= {shift_q[WORD_WIDTH-3:0], spi_event.si};
        end
    end

    assign word_in   = {shift_q, spi_event.si};
    assign word_done = spi_event.capture && (bit_cnt == LAST_BIT);

    // ----------------------------------------------------------------------
    // Receive stream register
    // ----------------------------------------------------------------------

    // A waiting word blocks the load, the new word is dropped
    assign word_held = rx_tvalid && !rx_tready;

    always_ff @(posedge aclk) begin
        if (word_done && !word_held) begin
            rx_tdata <= word_in;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rx_tvalid <= 1'b0;
        end else if (word_done) begin
            rx_tvalid <= 1'b1;
        end else if (rx_tready) begin
            rx_tvalid <= 1'b0;
        end
    end

endmodule

// ==== spi_slave/spi_tx_serializer.sv ====
// SPI transmit serializer

`timescale 1ns/1ps

module spi_tx_serializer
    import spi_pins_pkg::*, spi_word_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  spi_event_t spi_event,
    input  logic       ss_n,
    input  spi_word_t  tx_tdata,
    input  logic       tx_tvalid,
    output logic       tx_tready,
    output logic       so,
    output logic       so_en
);

    bit_index_t            bit_cnt;
    logic [WORD_WIDTH-2:0] shift_q;
    spi_word_t             word_load;

    // ----------------------------------------------------------------------
    // Bit counter on launch events
    // ----------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            bit_cnt <= FIRST_BIT;
        end else if (!spi_event.selected) begin
            bit_cnt <= FIRST_BIT;
        end else if (spi_event.launch) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // One-cycle request at the start of each word
    assign tx_tready = spi_event.launch && (bit_cnt == FIRST_BIT);

    // Nothing offered means a word of zeros
    assign word_load = tx_tvalid ? tx_tdata : '0;

    // ----------------------------------------------------------------------
    // Output shifter, MSB first
    // ----------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            so <= 1'b0;
        end else if (tx_tready) begin
            so <= word_load[WORD_WIDTH-1];
        end else if (spi_event.launch) begin
            so <= shift_q[WORD_WIDTH-2];
        end
    end

    always_ff @(posedge aclk) begin
        if (tx_tready) begin
            shift_q <= word_load[WORD_WIDTH-2:0];
        end else if (spi_event.launch) begin
            shift_q <= {shift_q[WORD_WIDTH-3:0], 1'b0};
        end
    end

    // Drive SO straight from the raw select pin
    assign so_en = !ss_n;

endmodule

// ==== spi_slave/spi_slave_top.sv ====
// SPI slave top level

`timescale 1ns/1ps

module spi_slave_top
    import spi_pins_pkg::*, spi_word_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,

    // SPI pins
    input  logic      sck,
    input  logic      ss_n,
    input  logic      si,
    output logic      so,
    output logic      so_en,

    // Receive stream
    output spi_word_t rx_tdata,
    output logic      rx_tvalid,
    input  logic      rx_tready,

    // Transmit stream
    input  spi_word_t tx_tdata,
    input  logic      tx_tvalid,
    output logic      tx_tready
);

    spi_pins_t  pins_sync;
    spi_event_t spi_event;

    // ----------------------------------------------------------------------
    // Pin side
    // ----------------------------------------------------------------------

    spi_pin_sync i_pin_sync (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .sck       (sck),
        .ss_n      (ss_n),
        .si        (si),
        .pins_sync (pins_sync)
    );

    spi_edge_detect i_edge_detect (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .pins_sync (pins_sync),
        .spi_event (spi_event)
    );

    // ----------------------------------------------------------------------
    // Data paths
    // ----------------------------------------------------------------------

    spi_rx_deserializer i_rx_deserializer (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .spi_event (spi_event),
        .rx_tdata  (rx_tdata),
        .rx_tvalid (rx_tvalid),
        .rx_tready (rx_tready)
    );

    spi_tx_serializer i_tx_serializer (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .spi_event (spi_event),
        .ss_n      (ss_n),
        .tx_tdata  (tx_tdata),
        .tx_tvalid (tx_tvalid),
        .tx_tready (tx_tready),
        .so        (so),
        .so_en     (so_en)
    );

endmodule

// ==== verification/spi_slave_properties.sv ====
// SPI slave stream and pin properties

`timescale 1ns/1ps

module spi_slave_properties
    import spi_word_pkg::*;
(
    input logic      aclk,
    input logic      aresetn,
    input logic      ss_n,
    input logic      so_en,
    input spi_word_t rx_tdata,
    input logic      rx_tvalid,
    input logic      rx_tready,
    input logic      tx_tready
);

    // Count of failed properties
    int failures = 0;

    // A waiting receive word holds still
    rx_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        rx_tvalid && !rx_tready |=> rx_tvalid && $stable(rx_tdata))
        else begin
            failures++;
            $error("rx_tdata or rx_tvalid changed while waiting");
        end

    tx_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        tx_tready |=> !tx_tready)
        else begin
            failures++;
            $error("tx_tready high for two cycles");
        end

    so_drive: assert property (@(posedge aclk) so_en == !ss_n)
        else begin
            failures++;
            $error("so_en does not follow ss_n");
        end

    reset_idle: assert property (@(posedge aclk) !aresetn |=> !rx_tvalid && !tx_tready)
        else begin
            failures++;
            $error("stream outputs not idle after reset");
        end

endmodule

bind spi_slave_top spi_slave_properties i_properties (.*);

// ==== verification/spi_slave_tb.sv ====
// SPI slave testbench

`timescale 1ns/1ps

module spi_slave_tb
    import spi_word_pkg::*;
;

    localparam int NUM_FRAMES = 16;
    localparam int HALF = 8;

    logic aclk = 1'b0;
    logic aresetn = 1'b0;
    logic sck = 1'b0;
    logic ss_n = 1'b1;
    logic si = 1'b0;
    logic rx_tready = 1'b0;
    logic tx_tvalid = 1'b0;
    spi_word_t tx_tdata = '0;
    logic so, so_en, rx_tvalid, tx_tready;
    spi_word_t rx_tdata;
    spi_word_t rx_got[$];
    logic [31:0] lfsr = 32'hfa6e1f51;
    int checks = 0;
    int errors = 0;
    int test_errors;

    spi_slave_top i_dut (.*);

    always #2 aclk = !aclk;

    // Receive stream monitor
    always @(posedge aclk) begin
        if (rx_tvalid && rx_tready) rx_got.push_back(rx_tdata);
    end

    // Watchdog
    initial begin
        #(4 * (NUM_FRAMES * 2 * HALF * (WORD_WIDTH + 1) + 2000));
        $display("Watchdog expired, the run did not finish in time");
        $display("Checks failed");
        $finish;
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        repeat (n) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Testbench errors plus bound assertion failures
    function automatic int error_count();
        return errors + i_dut.i_properties.failures;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // Step on falling edges and check so_en on each
    task automatic step_cycles(input int n);
        repeat (n) begin
            @(negedge aclk);
            check_value("so_en", !ss_n, so_en);
        end
    endtask

    // ----------------------------------------------------------------------
    // SPI master in mode 1
    // ----------------------------------------------------------------------

    task automatic run_frame(input spi_word_t mosi, input logic offer,
                             input spi_word_t tx_word, input int nbits);
        spi_word_t miso;
        tx_tvalid = offer;
        tx_tdata  = tx_word;
        ss_n = 1'b0;
        step_cycles(HALF);
        for (int i = 0; i < nbits; i++) begin
            sck = 1'b1;
            step_cycles(1);
            si = mosi[WORD_WIDTH-1-i];
            step_cycles(HALF - 1);
            miso[WORD_WIDTH-1-i] = so;
            sck = 1'b0;
            step_cycles(HALF);
        end
        ss_n = 1'b1;
        tx_tvalid = 1'b0;
        if (nbits == WORD_WIDTH) check_value("so", offer ? tx_word : '0, miso);
        step_cycles(HALF);
    endtask

    task automatic expect_rx(input spi_word_t exp);
        int waited;
        waited = 0;
        while (rx_got.size() == 0 && waited < 64) begin
            step_cycles(1);
            waited++;
        end
        checks++;
        assert (rx_got.size() != 0) else begin
            errors++;
            $display("No receive word arrived at %0t ns", $time);
        end
        if (rx_got.size() != 0) check_value("rx_tdata", exp, rx_got.pop_front());
    endtask

    task automatic expect_no_rx();
        step_cycles(16);
        checks++;
        assert (rx_got.size() == 0) else begin
            errors++;
            $display("Unexpected receive word at %0t ns", $time);
            rx_got.delete();
        end
    endtask

    task automatic report(input string name);
        $display("%s: %s", name, (error_count() == test_errors) ? "passed" : "failed");
        test_errors = error_count();
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------

    initial begin
        logic [31:0] a, b, n;
        test_errors = 0;
        repeat (5) @(negedge aclk);
        aresetn = 1'b1;
        step_cycles(1);
        check_value("rx_tvalid", 0, rx_tvalid);
        check_value("tx_tready", 0, tx_tready);
        check_value("so", 0, so);
        report("Test 5 reset state");

        rx_tready = 1'b1;
        repeat (6) begin
            a = random_bits(WORD_WIDTH);
            run_frame(a, 1'b0, '0, WORD_WIDTH);
            expect_rx(a);
        end
        report("Test 1 receive words");

        repeat (6) begin
            a = random_bits(WORD_WIDTH);
            b = random_bits(WORD_WIDTH);
            n = random_bits(1);
            run_frame(a, n[0], b, WORD_WIDTH);
            expect_rx(a);
        end
        report("Test 2 transmit words");

        rx_tready = 1'b0;
        a = random_bits(WORD_WIDTH);
        b = random_bits(WORD_WIDTH);
        run_frame(a, 1'b0, '0, WORD_WIDTH);
        run_frame(b, 1'b0, '0, WORD_WIDTH);
        rx_tready = 1'b1;
        expect_rx(a);
        expect_no_rx();
        report("Test 3 back-pressure");

        n = random_bits(3);
        a = random_bits(WORD_WIDTH);
        run_frame(a, 1'b0, '0, (n % 7) + 1);
        expect_no_rx();
        a = random_bits(WORD_WIDTH);
        b = random_bits(WORD_WIDTH);
        run_frame(a, 1'b1, b, WORD_WIDTH);
        expect_rx(a);
        report("Test 4 aborted frame");

        $display("Checks run: %0d, errors: %0d", checks, error_count());
        if (error_count() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
common/spi_pins_pkg.sv
common/spi_word_pkg.sv
logic/spi_pin_sync.sv
logic/spi_edge_detect.sv
spi_slave/spi_rx_deserializer.sv
spi_slave/spi_tx_serializer.sv
spi_slave/spi_slave_top.sv
verification/spi_slave_properties.sv
verification/spi_slave_tb.sv

// ==== Bender.yml ====
package:
  name: spi_slave

sources:
  - common/spi_pins_pkg.sv
  - common/spi_word_pkg.sv
  - logic/spi_pin_sync.sv
  - logic/spi_edge_detect.sv
  - spi_slave/spi_rx_deserializer.sv
  - spi_slave/spi_tx_serializer.sv
  - spi_slave/spi_slave_top.sv
  - target: test
    files:
      - verification/spi_slave_properties.sv
      - verification/spi_slave_tb.sv
